//--- fifo_asym_top.f
fifo_geom_pkg.sv
fifo_mem_pkg.sv
fifo_ctrl.sv
fifo_asym_conv.sv
fifo_ram.sv
fifo_asym_top.sv
fifo_asym_top_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fifo_asym_top_tb
FILELIST  = fifo_asym_top.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- fifo_asym_top_tb.sv
`timescale 1ns/1ps

module fifo_asym_top_tb;

   import fifo_geom_pkg::*;

   localparam int WORD_BYTES  = R_DATA_W / W_DATA_W;
   localparam int RAND_CYCLES = 1800;
   // random phase plus directed tests and drains, with margin
   localparam int MAX_CYCLES  = 2 * (RAND_CYCLES + 200);

   logic    clk_i;
   logic    rst_n_i;
   logic    w_en_i;
   w_data_t w_data_i;
   logic    w_full_o;
   logic    r_en_i;
   r_data_t r_data_o;
   logic    r_empty_o;
   level_t  level_o;

   integer  seed;
   int      cycle_cnt  = 0;
   int      err_cnt    = 0;
   int      chk_cnt    = 0;
   int      words_read = 0;

   // reference model state
   logic [W_DATA_W-1:0] model_q[$];
   logic    model_live     = 1'b0;
   logic    have_word      = 1'b0;
   r_data_t last_word      = '0;
   logic    w_acc;
   logic    r_acc;

   fifo_asym_top UUT (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // oldest byte lands in the least significant lane
   function automatic r_data_t pop_word();
      r_data_t word;
      word = '0;
      for (int i = 0; i < WORD_BYTES; i++) begin
         word[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();
      end
      return word;
   endfunction

   task automatic check_data(input r_data_t got, input r_data_t exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Error at time %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input level_t got, input level_t exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Error at time %0t: %s got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Error at time %0t: %s got %b, expected %b", $time, what, got, exp);
      end
   endtask

   // model follows the accepted strobes at each rising edge
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         model_q.delete();
         have_word      = 1'b0;
         model_live     = 1'b1;
      end else begin
         w_acc = w_en_i && (model_q.size() < int'(FIFO_SIZE));
         r_acc = r_en_i && (model_q.size() >= WORD_BYTES);
         // registered read, the word is on r_data_o right after this edge
         if (r_acc) begin
            last_word = pop_word();
            have_word = 1'b1;
            words_read++;
         end
         if (w_acc) begin
            model_q.push_back(w_data_i);
         end
      end
   end

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk_i) begin
      if (model_live) begin
         check_level(level_o, level_t'(model_q.size()), "level");
         check_flag(w_full_o, model_q.size() == int'(FIFO_SIZE), "full flag");
         check_flag(r_empty_o, model_q.size() < WORD_BYTES, "empty flag");
         if (have_word) begin
            check_data(r_data_o, last_word, "read word");
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic step(input logic we, input w_data_t wd, input logic re);
      @(negedge clk_i);
      w_en_i   = we;
      w_data_i = wd;
      r_en_i   = re;
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, '0, 1'b0);
   endtask

   task automatic write_until_full();
      logic [31:0] rnd;
      @(negedge clk_i);
      while (!w_full_o) begin
         rnd      = $random(seed);
         w_en_i   = 1'b1;
         w_data_i = rnd[7:0];
         @(negedge clk_i);
      end
      w_en_i = 1'b0;
   endtask

   task automatic read_until_empty();
      @(negedge clk_i);
      while (!r_empty_o) begin
         r_en_i = 1'b1;
         @(negedge clk_i);
      end
      r_en_i = 1'b0;
      // short gap before the next test
      idle(2);
   endtask

   task automatic random_phase(input int cycles, input int w_pct, input int r_pct);
      logic [31:0] rnd;
      for (int n = 0; n < cycles; n++) begin
         @(negedge clk_i);
         rnd      = $random(seed);
         w_en_i   = (int'(rnd[15:0]) % 100) < w_pct;
         r_en_i   = (int'(rnd[31:16]) % 100) < r_pct;
         rnd      = $random(seed);
         w_data_i = rnd[7:0];
      end
      w_en_i = 1'b0;
      r_en_i = 1'b0;
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
      end
   endtask

   initial begin
      int errs_before;
      seed     = 32'h5d309be9;
      rst_n_i  = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;

      repeat (5) @(negedge clk_i);
      rst_n_i = 1'b1;

      errs_before = err_cnt;
      check_level(level_o, '0, "level after reset");
      check_flag(r_empty_o, 1'b1, "empty after reset");
      check_flag(w_full_o, 1'b0, "full after reset");
      report_test(1, "reset values", errs_before);

      errs_before = err_cnt;
      for (int i = 0; i < 4; i++) begin
         step(1'b1, w_data_t'(8'h11 * (i + 1)), 1'b0);
         // fewer than four bytes still reads as empty
         check_flag(r_empty_o, 1'b1, "empty below one word");
      end
      idle(1);
      check_flag(r_empty_o, 1'b0, "empty after four bytes");
      check_level(level_o, level_t'(4), "level after four bytes");
      step(1'b0, '0, 1'b1);
      idle(2);
      check_data(r_data_o, 32'h44332211, "first word lanes");
      report_test(2, "four bytes to one word", errs_before);

      errs_before = err_cnt;
      write_until_full();
      check_level(level_o, level_t'(64), "level when full");
      step(1'b1, 8'ha5, 1'b0);
      idle(1);
      check_level(level_o, level_t'(64), "level after write while full");
      check_flag(w_full_o, 1'b1, "full after write while full");
      read_until_empty();
      report_test(3, "fill to full", errs_before);

      errs_before = err_cnt;
      step(1'b0, '0, 1'b1);
      idle(2);
      check_level(level_o, '0, "level after read while empty");
      check_data(r_data_o, last_word, "data held after read while empty");
      report_test(4, "read while empty", errs_before);

      errs_before = err_cnt;
      random_phase(RAND_CYCLES / 3, 70, 30);
      random_phase(RAND_CYCLES / 3, 50, 50);
      random_phase(RAND_CYCLES / 3, 30, 70);
      read_until_empty();
      report_test(5, "random traffic", errs_before);

      $display("checks %0d, errors %0d, words read %0d", chk_cnt, err_cnt, words_read);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- fifo_asym_top.sv
`timescale 1ns/1ps

module fifo_asym_top (
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   // write side
   input  logic                    w_en_i,
   input  fifo_geom_pkg::w_data_t  w_data_i,
   output logic                    w_full_o,

   // read side
   input  logic                    r_en_i,
   output fifo_geom_pkg::r_data_t  r_data_o,
   output logic                    r_empty_o,

   output fifo_geom_pkg::level_t   level_o
);

   import fifo_geom_pkg::*;
   import fifo_mem_pkg::*;

   logic      w_take;
   logic      r_take;
   w_addr_t   w_addr;
   r_addr_t   r_addr;

   lane_en_t  mem_w_en;
   mem_addr_t mem_w_addr;
   mem_word_t mem_w_data;
   logic      mem_r_en;
   mem_addr_t mem_r_addr;
   mem_word_t mem_r_data;

   fifo_ctrl u_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_take_o  (w_take),
      .r_take_o  (r_take),
      .w_addr_o  (w_addr),
      .r_addr_o  (r_addr),
      .level_o   (level_o),
      .w_full_o  (w_full_o),
      .r_empty_o (r_empty_o)
   );

   fifo_asym_conv u_conv (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .w_take_i     (w_take),
      .w_addr_i     (w_addr),
      .w_data_i     (w_data_i),
      .r_take_i     (r_take),
      .r_addr_i     (r_addr),
      .r_data_o     (r_data_o),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .mem_r_data_i (mem_r_data)
   );

   fifo_ram u_ram (
      .clk_i    (clk_i),
      .w_en_i   (mem_w_en),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_en_i   (mem_r_en),
      .r_addr_i (mem_r_addr),
      .r_data_o (mem_r_data)
   );

endmodule

//--- fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
   input  logic                      clk_i,

   input  fifo_mem_pkg::lane_en_t    w_en_i,
   input  fifo_mem_pkg::mem_addr_t   w_addr_i,
   input  fifo_mem_pkg::mem_word_t   w_data_i,

   input  logic                      r_en_i,
   input  fifo_mem_pkg::mem_addr_t   r_addr_i,
   output fifo_mem_pkg::mem_word_t   r_data_o
);

   import fifo_geom_pkg::*;
   import fifo_mem_pkg::*;

   mem_word_t mem [MEM_DEPTH];
   mem_word_t r_data_q;

   // byte-lane writes, lane k is bits k*MINDATA_W upward
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < RATIO; i++) begin
         if (w_en_i[i]) begin
            mem[w_addr_i][i*MINDATA_W +: MINDATA_W] <= w_data_i[i*MINDATA_W +: MINDATA_W];
         end
      end
   end

   // read register holds between reads
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_q <= mem[r_addr_i];
      end
   end

   assign r_data_o = r_data_q;

endmodule

//--- fifo_asym_conv.sv
`timescale 1ns/1ps

module fifo_asym_conv (
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   input  logic                      w_take_i,
   input  fifo_geom_pkg::w_addr_t    w_addr_i,
   input  fifo_geom_pkg::w_data_t    w_data_i,

   input  logic                      r_take_i,
   input  fifo_geom_pkg::r_addr_t    r_addr_i,
   output fifo_geom_pkg::r_data_t    r_data_o,

   output fifo_mem_pkg::lane_en_t    mem_w_en_o,
   output fifo_mem_pkg::mem_addr_t   mem_w_addr_o,
   output fifo_mem_pkg::mem_word_t   mem_w_data_o,
   output logic                      mem_r_en_o,
   output fifo_mem_pkg::mem_addr_t   mem_r_addr_o,
   input  fifo_mem_pkg::mem_word_t   mem_r_data_i
);

   import fifo_geom_pkg::*;
   import fifo_mem_pkg::*;

   generate
      if (W_DATA_W < R_DATA_W) begin : g_w_narrow
         lane_sel_t w_lane;

         // low bits pick the lane, the rest is the word
         assign w_lane       = w_addr_i[LANE_W-1:0];
         assign mem_w_addr_o = w_addr_i[LANE_W +: MEM_ADDR_W];
         assign mem_w_en_o   = w_take_i ? (lane_en_t'(1) << w_lane) : '0;
         // same byte on every lane, the enable decides where it lands
         assign mem_w_data_o = {RATIO{w_data_i}};
      end else begin : g_w_wide
         assign mem_w_addr_o = w_addr_i;
         assign mem_w_en_o   = {RATIO{w_take_i}};
         assign mem_w_data_o = w_data_i;
      end
   endgenerate

   assign mem_r_en_o = r_take_i;

   generate
      if (R_DATA_W < W_DATA_W) begin : g_r_narrow
         lane_sel_t r_lane_q;

         assign mem_r_addr_o = r_addr_i[LANE_W +: MEM_ADDR_W];

         // lane travels alongside the memory read register
         always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
               r_lane_q <= '0;
            end else if (r_take_i) begin
               r_lane_q <= r_addr_i[LANE_W-1:0];
            end
         end

         assign r_data_o = mem_r_data_i[r_lane_q*MINDATA_W +: MINDATA_W];
      end else begin : g_r_wide
         assign mem_r_addr_o = r_addr_i;
         assign r_data_o     = mem_r_data_i;
      end
   endgenerate

   // narrow writes hit one lane, wide writes fill the word
   a_lane_en_shape: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (mem_w_en_o != '0) |-> ($onehot(mem_w_en_o) || (&mem_w_en_o))
   ) else $error("fifo_asym_conv: bad lane enable %b", mem_w_en_o);

endmodule

//--- fifo_ctrl.sv
`timescale 1ns/1ps

module fifo_ctrl (
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   input  logic                    w_en_i,
   input  logic                    r_en_i,

   output logic                    w_take_o,
   output logic                    r_take_o,
   output fifo_geom_pkg::w_addr_t  w_addr_o,
   output fifo_geom_pkg::r_addr_t  r_addr_o,

   output fifo_geom_pkg::level_t   level_o,
   output logic                    w_full_o,
   output logic                    r_empty_o
);

   import fifo_geom_pkg::*;

   logic    w_take;
   logic    r_take;
   w_addr_t w_addr_q;
   r_addr_t r_addr_q;
   level_t  level_q;
   level_t  level_nxt;
   logic    w_full_q;
   logic    r_empty_q;

   // strobes only count when the flags allow them
   assign w_take = w_en_i & ~w_full_q;
   assign r_take = r_en_i & ~r_empty_q;

   // write pointer, wraps at the end of the array
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_addr_q <= '0;
      end else if (w_take) begin
         w_addr_q <= w_addr_q + 1'b1;
      end
   end

   // read pointer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_addr_q <= '0;
      end else if (r_take) begin
         r_addr_q <= r_addr_q + 1'b1;
      end
   end

   // level in narrow units
   always_comb begin
      level_nxt = level_q;
      case ({w_take, r_take})
         2'b10: begin
            level_nxt = level_q + W_INCR;
         end
         2'b01: begin
            level_nxt = level_q - R_INCR;
         end
         2'b11: begin
            level_nxt = level_q + W_INCR - R_INCR;
         end
         default: begin
            level_nxt = level_q;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_nxt;
      end
   end

   // flags come from the next level, so they are exact right after the edge
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_full_q  <= 1'b0;
         r_empty_q <= 1'b1;
      end else begin
         w_full_q  <= level_nxt > (FIFO_SIZE - W_INCR);
         r_empty_q <= level_nxt < R_INCR;
      end
   end

   assign w_take_o  = w_take;
   assign r_take_o  = r_take;
   assign w_addr_o  = w_addr_q;
   assign r_addr_o  = r_addr_q;
   assign level_o   = level_q;
   assign w_full_o  = w_full_q;
   assign r_empty_o = r_empty_q;

   // no overflow, the write mask must hold the level within capacity
   a_level_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      level_q <= FIFO_SIZE
   ) else $error("fifo_ctrl: level %0d above capacity", level_q);

   // registered empty flag tracks the registered level
   a_empty_match: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      r_empty_q == (level_q < R_INCR)
   ) else $error("fifo_ctrl: empty flag out of step with level %0d", level_q);

endmodule

//--- fifo_mem_pkg.sv
package fifo_mem_pkg;

   import fifo_geom_pkg::*;

   // memory is always organized in wide words
   localparam int MEM_ADDR_W = ADDR_W - LANE_W;
   localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [MAXDATA_W-1:0]  mem_word_t;

   // one enable bit per narrow lane of a word
   typedef logic [RATIO-1:0]  lane_en_t;
   typedef logic [LANE_W-1:0] lane_sel_t;

endpackage

//--- fifo_geom_pkg.sv
package fifo_geom_pkg;

   // port widths, narrow side is the addressing unit
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;
   localparam int ADDR_W   = 6;

   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int RATIO     = MAXDATA_W / MINDATA_W;
   localparam int LANE_W    = $clog2(RATIO);

   // the wide side counts whole words, the narrow side counts units
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? ADDR_W - LANE_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? ADDR_W - LANE_W : ADDR_W;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;
   typedef logic [W_ADDR_W-1:0] w_addr_t;
   typedef logic [R_ADDR_W-1:0] r_addr_t;

   // one extra bit so a completely full FIFO can be told apart from empty
   typedef logic [ADDR_W:0] level_t;

   // level step per access, in narrow units
   localparam level_t W_INCR = (W_DATA_W > R_DATA_W) ? level_t'(RATIO) : level_t'(1);
   localparam level_t R_INCR = (R_DATA_W > W_DATA_W) ? level_t'(RATIO) : level_t'(1);

   // capacity in narrow units
   localparam level_t FIFO_SIZE = level_t'(1) << ADDR_W;

endpackage
